/* build.f */
md_types_pkg.sv
md_ctrl_pkg.sv
force_pe.sv
force_wb_arbiter.sv
force_cache.sv
particle_store.sv
broadcast_controller.sv
motion_update.sv
md_step_top.sv
tb_md_step.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_md_step -o sim_md_step \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_md_step | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tb_md_step.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_md_step;

	import md_types_pkg::*;

	localparam int NUM_CELLS = 4;
	localparam int PPC = 8;
	localparam int CELL_W = $clog2(NUM_CELLS);
	localparam int PART_W = $clog2(PPC);
	localparam int TOTAL = NUM_CELLS * PPC;
	// One step from rest, five in a row, one near the wrap limits, one with an extra start
	localparam int NUM_STEPS = 8;
	localparam int WATCHDOG_CYCLES = 4000 * NUM_STEPS;

	logic clk = 1'b0;
	logic rst, load_en, start, busy, done;
	logic [CELL_W-1:0] load_cell, rd_cell;
	logic [PART_W-1:0] load_addr, rd_addr;
	data_t load_pos, load_vel, rd_pos, rd_vel;

	// Expected particle state
	data_t pos_m [NUM_CELLS][PPC];
	data_t vel_m [NUM_CELLS][PPC];

	md_step_top #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PPC)) dut0 (
		.clk(clk), .rst(rst), .load_en(load_en), .load_cell(load_cell),
		.load_addr(load_addr), .load_pos(load_pos), .load_vel(load_vel),
		.start(start), .busy(busy), .done(done), .rd_cell(rd_cell), .rd_addr(rd_addr),
		.rd_pos(rd_pos), .rd_vel(rd_vel)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run("Control flag mismatch");
		end
	endtask

	task automatic check_pos(input int c, input int p, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAILED: rd_pos cell %0d addr %0d got 0x%04h expected 0x%04h", c, p, got, exp);
			abort_run("Position mismatch");
		end
	endtask

	task automatic check_vel(input int c, input int p, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAILED: rd_vel cell %0d addr %0d got 0x%04h expected 0x%04h", c, p, got, exp);
			abort_run("Velocity mismatch");
		end
	endtask

	function automatic data_t rand_signed(input int lim);
		return data_t'(int'($urandom % (2 * lim + 1)) - lim);
	endfunction

	task automatic fill_small(input int vel_lim);
		for (int c = 0; c < NUM_CELLS; c++)
			for (int p = 0; p < PPC; p++) begin
				pos_m[c][p] = rand_signed(200);
				vel_m[c][p] = rand_signed(vel_lim);
			end
	endtask

	// Even cells sit just below the top, odd cells just above the bottom
	task automatic fill_wrap();
		for (int c = 0; c < NUM_CELLS; c++)
			for (int p = 0; p < PPC; p++) begin
				if (c % 2 == 0)
					pos_m[c][p] = data_t'(32767 - int'($urandom % 101));
				else
					pos_m[c][p] = data_t'(-32768 + int'($urandom % 101));
				vel_m[c][p] = rand_signed(300);
			end
	endtask

	task automatic load_model();
		for (int i = 0; i < TOTAL; i++) begin
			@(negedge clk);
			load_en = 1'b1;
			load_cell = CELL_W'(i / PPC);
			load_addr = PART_W'(i % PPC);
			load_pos = pos_m[i / PPC][i % PPC];
			load_vel = vel_m[i / PPC][i % PPC];
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	// The next address is already applied when the previous particle is checked,
	// so data must trail its address by exactly one clock
	task automatic check_all();
		int c;
		int p;
		for (int i = 0; i <= TOTAL; i++) begin
			@(negedge clk);
			if (i < TOTAL) begin
				rd_cell = CELL_W'(i / PPC);
				rd_addr = PART_W'(i % PPC);
			end
			#1;
			if (i > 0) begin
				c = (i - 1) / PPC;
				p = (i - 1) % PPC;
				check_pos(c, p, rd_pos, pos_m[c][p]);
				check_vel(c, p, rd_vel, vel_m[c][p]);
			end
		end
	endtask

	// Forces from the old positions, then v += f and x += v
	task automatic model_step();
		data_t frc [NUM_CELLS][PPC];
		data_t d;
		int nc;
		for (int c = 0; c < NUM_CELLS; c++) begin
			nc = (c + 1) % NUM_CELLS;
			for (int r = 0; r < PPC; r++) begin
				frc[c][r] = '0;
				for (int n = 0; n < PPC; n++) begin
					d = pos_m[nc][n] - pos_m[c][r];
					frc[c][r] = frc[c][r] + (d >>> FORCE_SHIFT);
				end
			end
		end
		for (int c = 0; c < NUM_CELLS; c++)
			for (int r = 0; r < PPC; r++) begin
				vel_m[c][r] = vel_m[c][r] + frc[c][r];
				pos_m[c][r] = pos_m[c][r] + vel_m[c][r];
			end
	endtask

	task automatic wait_done();
		do
			@(negedge clk);
		while (done !== 1'b1);
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("Timeout, done never arrived within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		void'($urandom(81397));
		rst = 1'b1;
		load_en = 1'b0;
		load_cell = '0;
		load_addr = '0;
		load_pos = '0;
		load_vel = '0;
		start = 1'b0;
		rd_cell = '0;
		rd_addr = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);

		// Load and readback, then one step from rest
		fill_small(0);
		load_model();
		check_all();
		pulse_start();
		wait_done();
		model_step();
		check_all();

		// Several steps in a row with moving particles
		fill_small(50);
		load_model();
		for (int s = 0; s < 5; s++) begin
			pulse_start();
			wait_done();
			model_step();
			check_all();
		end

		// Wraparound near the word limits
		fill_wrap();
		load_model();
		pulse_start();
		wait_done();
		model_step();
		check_all();

		// Extra start while busy must be ignored
		fill_small(50);
		load_model();
		pulse_start();
		repeat (3) @(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_done();
		model_step();
		repeat (100) begin
			@(negedge clk);
			check_flag("done", done, 1'b0);
		end
		check_flag("busy", busy, 1'b0);
		check_all();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* md_step_top.sv */
`timescale 1ns/10ps
`default_nettype none

module md_step_top #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int CELL_W = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_en,
	input  logic [CELL_W-1:0]   load_cell,
	input  logic [PART_W-1:0]   load_addr,
	input  md_types_pkg::data_t load_pos,
	input  md_types_pkg::data_t load_vel,
	input  logic                start,
	output logic                busy,
	output logic                done,
	input  logic [CELL_W-1:0]   rd_cell,
	input  logic [PART_W-1:0]   rd_addr,
	output md_types_pkg::data_t rd_pos,
	output md_types_pkg::data_t rd_vel
);

	import md_types_pkg::*;

	logic [PART_W-1:0] ref_id, nb_id, mu_addr, fc_addr;
	logic pair_valid, last_nb, mu_start, mu_done, mu_clear, mu_we, fc_we;
	logic [NUM_CELLS-1:0] pe_busy, wb_req, wb_ack;
	logic [NUM_CELLS*PART_W-1:0] wb_addr;
	logic [NUM_CELLS*DATA_WIDTH-1:0] wb_force, ref_pos, nb_pos, mu_force;
	logic [NUM_CELLS*DATA_WIDTH-1:0] mu_pos, mu_vel, mu_new_pos, mu_new_vel;
	logic [CELL_W-1:0] fc_cell;
	data_t fc_data;

	broadcast_controller #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PARTICLES_PER_CELL)) bc0 (
		.clk(clk), .rst(rst), .start(start), .pe_busy(pe_busy), .mu_done(mu_done),
		.ref_id(ref_id), .nb_id(nb_id), .pair_valid(pair_valid), .last_nb(last_nb),
		.mu_start(mu_start), .busy(busy), .done(done)
	);

	// PE i pairs its own cell with the next cell in the ring
	for (genvar i = 0; i < NUM_CELLS; i++) begin : g_pe
		localparam int NB = (i + 1) % NUM_CELLS;
		force_pe #(.PARTICLES_PER_CELL(PARTICLES_PER_CELL)) pe (
			.clk(clk), .rst(rst), .pair_valid(pair_valid), .last_nb(last_nb), .ref_id(ref_id),
			.ref_pos(ref_pos[i*DATA_WIDTH +: DATA_WIDTH]),
			.nb_pos(nb_pos[NB*DATA_WIDTH +: DATA_WIDTH]),
			.wb_req(wb_req[i]), .wb_addr(wb_addr[i*PART_W +: PART_W]),
			.wb_force(wb_force[i*DATA_WIDTH +: DATA_WIDTH]),
			.wb_ack(wb_ack[i]), .pe_busy(pe_busy[i])
		);
	end

	force_wb_arbiter #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PARTICLES_PER_CELL)) arb0 (
		.clk(clk), .rst(rst), .wb_req(wb_req), .wb_ack(wb_ack), .wb_addr(wb_addr),
		.wb_force(wb_force), .fc_we(fc_we), .fc_cell(fc_cell), .fc_addr(fc_addr),
		.fc_data(fc_data)
	);

	force_cache #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PARTICLES_PER_CELL)) fc0 (
		.clk(clk), .rst(rst), .fc_we(fc_we), .fc_cell(fc_cell), .fc_addr(fc_addr),
		.fc_data(fc_data), .mu_addr(mu_addr), .mu_clear(mu_clear), .mu_force(mu_force)
	);

	// Host loads only land while the engine is idle
	particle_store #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PARTICLES_PER_CELL)) ps0 (
		.clk(clk), .rst(rst), .ref_id(ref_id), .nb_id(nb_id), .ref_pos(ref_pos),
		.nb_pos(nb_pos), .load_en(load_en && !busy), .load_cell(load_cell),
		.load_addr(load_addr), .load_pos(load_pos), .load_vel(load_vel),
		.rd_cell(rd_cell), .rd_addr(rd_addr), .rd_pos(rd_pos), .rd_vel(rd_vel),
		.mu_addr(mu_addr), .mu_pos(mu_pos), .mu_vel(mu_vel), .mu_we(mu_we),
		.mu_new_pos(mu_new_pos), .mu_new_vel(mu_new_vel)
	);

	motion_update #(.NUM_CELLS(NUM_CELLS), .PARTICLES_PER_CELL(PARTICLES_PER_CELL)) mu0 (
		.clk(clk), .rst(rst), .mu_start(mu_start), .mu_addr(mu_addr), .mu_clear(mu_clear),
		.mu_we(mu_we), .mu_force(mu_force), .mu_pos(mu_pos), .mu_vel(mu_vel),
		.mu_new_pos(mu_new_pos), .mu_new_vel(mu_new_vel), .mu_done(mu_done)
	);

endmodule

`default_nettype wire

/* motion_update.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_update #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1,
	localparam int VEC_W = NUM_CELLS * md_types_pkg::DATA_WIDTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              mu_start,
	output logic [PART_W-1:0] mu_addr,
	output logic              mu_clear,
	output logic              mu_we,
	input  logic [VEC_W-1:0]  mu_force,
	input  logic [VEC_W-1:0]  mu_pos,
	input  logic [VEC_W-1:0]  mu_vel,
	output logic [VEC_W-1:0]  mu_new_pos,
	output logic [VEC_W-1:0]  mu_new_vel,
	output logic              mu_done
);

	import md_types_pkg::*;
	import md_ctrl_pkg::*;

	localparam logic [PART_W-1:0] LAST_ID = PART_W'(PARTICLES_PER_CELL - 1);

	mu_state_t state;

	assign mu_we = (state == MU_WRITE);
	assign mu_clear = (state == MU_WRITE);

	// v += f, then x += v with the new velocity
	always_comb begin
		data_t vel;
		data_t nv;
		for (int c = 0; c < NUM_CELLS; c++) begin
			vel = mu_vel[c*DATA_WIDTH +: DATA_WIDTH];
			nv = vel + data_t'(mu_force[c*DATA_WIDTH +: DATA_WIDTH]);
			mu_new_vel[c*DATA_WIDTH +: DATA_WIDTH] = nv;
			mu_new_pos[c*DATA_WIDTH +: DATA_WIDTH] = data_t'(mu_pos[c*DATA_WIDTH +: DATA_WIDTH]) + nv;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MU_IDLE;
			mu_addr <= '0;
			mu_done <= 1'b0;
		end else begin
			mu_done <= 1'b0;
			case (state)
				MU_IDLE: begin
					if (mu_start) begin
						mu_addr <= '0;
						state <= MU_READ;
					end
				end
				// Caches return data one cycle after the address
				MU_READ: state <= MU_WRITE;
				MU_WRITE: begin
					if (mu_addr == LAST_ID) begin
						mu_done <= 1'b1;
						state <= MU_IDLE;
					end else begin
						mu_addr <= mu_addr + 1'b1;
						state <= MU_READ;
					end
				end
				default: state <= MU_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* broadcast_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module broadcast_controller #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic [NUM_CELLS-1:0] pe_busy,
	input  logic                 mu_done,
	output logic [PART_W-1:0]    ref_id,
	output logic [PART_W-1:0]    nb_id,
	output logic                 pair_valid,
	output logic                 last_nb,
	output logic                 mu_start,
	output logic                 busy,
	output logic                 done
);

	import md_ctrl_pkg::*;

	localparam logic [PART_W-1:0] LAST_ID = PART_W'(PARTICLES_PER_CELL - 1);

	bc_state_t state;
	logic      pes_free;

	// A delayed last_nb still in flight means PEs have not yet flagged busy
	assign pes_free = (pe_busy == '0) && !last_nb;
	assign busy = (state != BC_IDLE);
	assign done = (state == BC_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BC_IDLE;
			ref_id <= '0;
			nb_id <= '0;
			pair_valid <= 1'b0;
			last_nb <= 1'b0;
			mu_start <= 1'b0;
		end else begin
			// Match the one-cycle position read
			pair_valid <= (state == BC_STREAM);
			last_nb <= (state == BC_STREAM) && (nb_id == LAST_ID);
			mu_start <= 1'b0;
			case (state)
				BC_IDLE: begin
					if (start) begin
						ref_id <= '0;
						nb_id <= '0;
						state <= BC_STREAM;
					end
				end
				BC_STREAM: begin
					if (nb_id == LAST_ID) begin
						nb_id <= '0;
						state <= (ref_id == LAST_ID) ? BC_DRAIN : BC_WAIT_WB;
					end else begin
						nb_id <= nb_id + 1'b1;
					end
				end
				BC_WAIT_WB: begin
					// ref_id moves only here so PEs latch the right one
					if (pes_free) begin
						ref_id <= ref_id + 1'b1;
						state <= BC_STREAM;
					end
				end
				BC_DRAIN: begin
					if (pes_free) begin
						mu_start <= 1'b1;
						state <= BC_MOTION;
					end
				end
				BC_MOTION: if (mu_done) state <= BC_DONE;
				BC_DONE: state <= BC_IDLE;
				default: state <= BC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* particle_store.sv */
`timescale 1ns/10ps
`default_nettype none

module particle_store #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int CELL_W = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1,
	localparam int VEC_W = NUM_CELLS * md_types_pkg::DATA_WIDTH
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [PART_W-1:0]   ref_id,
	input  logic [PART_W-1:0]   nb_id,
	output logic [VEC_W-1:0]    ref_pos,
	output logic [VEC_W-1:0]    nb_pos,
	input  logic                load_en,
	input  logic [CELL_W-1:0]   load_cell,
	input  logic [PART_W-1:0]   load_addr,
	input  md_types_pkg::data_t load_pos,
	input  md_types_pkg::data_t load_vel,
	input  logic [CELL_W-1:0]   rd_cell,
	input  logic [PART_W-1:0]   rd_addr,
	output md_types_pkg::data_t rd_pos,
	output md_types_pkg::data_t rd_vel,
	input  logic [PART_W-1:0]   mu_addr,
	output logic [VEC_W-1:0]    mu_pos,
	output logic [VEC_W-1:0]    mu_vel,
	input  logic                mu_we,
	input  logic [VEC_W-1:0]    mu_new_pos,
	input  logic [VEC_W-1:0]    mu_new_vel
);

	import md_types_pkg::*;

	data_t pos_mem [NUM_CELLS][PARTICLES_PER_CELL];
	data_t vel_mem [NUM_CELLS][PARTICLES_PER_CELL];

	// Host load and motion update never overlap
	always_ff @(posedge clk) begin
		if (load_en) begin
			pos_mem[load_cell][load_addr] <= load_pos;
			vel_mem[load_cell][load_addr] <= load_vel;
		end
		if (mu_we) begin
			for (int c = 0; c < NUM_CELLS; c++) begin
				pos_mem[c][mu_addr] <= mu_new_pos[c*DATA_WIDTH +: DATA_WIDTH];
				vel_mem[c][mu_addr] <= mu_new_vel[c*DATA_WIDTH +: DATA_WIDTH];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ref_pos <= '0;
			nb_pos <= '0;
			mu_pos <= '0;
			mu_vel <= '0;
			rd_pos <= '0;
			rd_vel <= '0;
		end else begin
			// Every cell reads the same broadcast ids
			for (int c = 0; c < NUM_CELLS; c++) begin
				ref_pos[c*DATA_WIDTH +: DATA_WIDTH] <= pos_mem[c][ref_id];
				nb_pos[c*DATA_WIDTH +: DATA_WIDTH] <= pos_mem[c][nb_id];
				mu_pos[c*DATA_WIDTH +: DATA_WIDTH] <= pos_mem[c][mu_addr];
				mu_vel[c*DATA_WIDTH +: DATA_WIDTH] <= vel_mem[c][mu_addr];
			end
			rd_pos <= pos_mem[rd_cell][rd_addr];
			rd_vel <= vel_mem[rd_cell][rd_addr];
		end
	end

endmodule

`default_nettype wire

/* force_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module force_cache #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int CELL_W = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          fc_we,
	input  logic [CELL_W-1:0]                             fc_cell,
	input  logic [PART_W-1:0]                             fc_addr,
	input  md_types_pkg::data_t                           fc_data,
	input  logic [PART_W-1:0]                             mu_addr,
	input  logic                                          mu_clear,
	output logic [NUM_CELLS*md_types_pkg::DATA_WIDTH-1:0] mu_force
);

	import md_types_pkg::*;

	data_t mem [NUM_CELLS][PARTICLES_PER_CELL];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < NUM_CELLS; c++)
				for (int p = 0; p < PARTICLES_PER_CELL; p++)
					mem[c][p] <= '0;
		end else begin
			if (fc_we)
				mem[fc_cell][fc_addr] <= fc_data;
			// Consumed forces start the next step at zero
			if (mu_clear)
				for (int c = 0; c < NUM_CELLS; c++)
					mem[c][mu_addr] <= '0;
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_CELLS; c++)
			mu_force[c*DATA_WIDTH +: DATA_WIDTH] <= mem[c][mu_addr];
	end

endmodule

`default_nettype wire

/* force_wb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module force_wb_arbiter #(
	parameter int NUM_CELLS = 4,
	parameter int PARTICLES_PER_CELL = 8,
	localparam int CELL_W = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic [NUM_CELLS-1:0]                       wb_req,
	output logic [NUM_CELLS-1:0]                       wb_ack,
	input  logic [NUM_CELLS*PART_W-1:0]                wb_addr,
	input  logic [NUM_CELLS*md_types_pkg::DATA_WIDTH-1:0] wb_force,
	output logic                                       fc_we,
	output logic [CELL_W-1:0]                          fc_cell,
	output logic [PART_W-1:0]                          fc_addr,
	output md_types_pkg::data_t                        fc_data
);

	import md_types_pkg::*;

	logic              active;
	logic [CELL_W-1:0] last_gnt;
	logic [CELL_W-1:0] pick;
	logic              found;

	// Rotating priority, search starts just after the last grant
	always_comb begin
		int idx;
		found = 1'b0;
		pick = last_gnt;
		for (int k = 1; k <= NUM_CELLS; k++) begin
			idx = int'(last_gnt) + k;
			if (idx >= NUM_CELLS)
				idx = idx - NUM_CELLS;
			if (!found && wb_req[idx]) begin
				found = 1'b1;
				pick = CELL_W'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			wb_ack <= '0;
			fc_we <= 1'b0;
			last_gnt <= CELL_W'(NUM_CELLS - 1);
		end else begin
			fc_we <= 1'b0;
			if (!active) begin
				if (found) begin
					active <= 1'b1;
					last_gnt <= pick;
					wb_ack[pick] <= 1'b1;
					fc_we <= 1'b1;
				end
			end else if (!wb_req[last_gnt]) begin
				// Requester released, close the handshake
				active <= 1'b0;
				wb_ack <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!active && found) begin
			fc_cell <= pick;
			fc_addr <= wb_addr[pick*PART_W +: PART_W];
			fc_data <= wb_force[pick*DATA_WIDTH +: DATA_WIDTH];
		end
	end

endmodule

`default_nettype wire

/* force_pe.sv */
`timescale 1ns/10ps
`default_nettype none

module force_pe #(
	parameter int PARTICLES_PER_CELL = 8,
	localparam int PART_W = (PARTICLES_PER_CELL > 1) ? $clog2(PARTICLES_PER_CELL) : 1
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                pair_valid,
	input  logic                last_nb,
	input  logic [PART_W-1:0]   ref_id,
	input  md_types_pkg::data_t ref_pos,
	input  md_types_pkg::data_t nb_pos,
	output logic                wb_req,
	output logic [PART_W-1:0]   wb_addr,
	output md_types_pkg::data_t wb_force,
	input  logic                wb_ack,
	output logic                pe_busy
);

	import md_types_pkg::*;
	import md_ctrl_pkg::*;

	pe_state_t state;
	data_t     acc;
	data_t     diff;
	data_t     pair_force;

	always_comb begin
		diff = nb_pos - ref_pos;
		pair_force = diff >>> FORCE_SHIFT;
	end

	assign wb_req = (state == PE_REQ);
	assign pe_busy = (state != PE_ACCUM);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= PE_ACCUM;
			acc <= '0;
		end else begin
			if (pair_valid) begin
				// Last neighbor hands the sum over to the writeback register
				if (last_nb)
					acc <= '0;
				else
					acc <= acc + pair_force;
			end
			case (state)
				PE_ACCUM: if (pair_valid && last_nb) state <= PE_REQ;
				PE_REQ: if (wb_ack) state <= PE_RELEASE;
				PE_RELEASE: if (!wb_ack) state <= PE_ACCUM;
				default: state <= PE_ACCUM;
			endcase
		end
	end

	// Held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (pair_valid && last_nb) begin
			wb_force <= acc + pair_force;
			wb_addr <= ref_id;
		end
	end

endmodule

`default_nettype wire

/* md_ctrl_pkg.sv */
`default_nettype none

package md_ctrl_pkg;

	// Broadcast controller sequence
	typedef enum logic [2:0] {
		BC_IDLE,
		BC_STREAM,
		BC_DRAIN,
		BC_WAIT_WB,
		BC_MOTION,
		BC_DONE
	} bc_state_t;

	// PE accumulate and four-phase writeback
	typedef enum logic [1:0] {PE_ACCUM, PE_REQ, PE_RELEASE} pe_state_t;

	// Motion update walk
	typedef enum logic [1:0] {MU_IDLE, MU_READ, MU_WRITE} mu_state_t;

endpackage

`default_nettype wire

/* md_types_pkg.sv */
`default_nettype none

package md_types_pkg;

	// Word width for positions, velocities and forces
	localparam int DATA_WIDTH = 16;

	// Two's-complement word, wraps on overflow
	typedef logic signed [DATA_WIDTH-1:0] data_t;

	// Pair difference is scaled down by this many bits
	localparam int FORCE_SHIFT = 3;

endpackage

`default_nettype wire
